//--- hw/obi_pkg.sv
/*
 * OBI data bus types
 * Address-phase request and response-phase payloads of the data port.
 * The req/gnt and rvalid strobes travel beside these structs.
 */

package obi_pkg;

    // ------------------------------------------------------------
    // Bus widths
    // ------------------------------------------------------------

    localparam int unsigned OBI_ADDR_WIDTH = 32;
    localparam int unsigned OBI_DATA_WIDTH = 32;

    // One byte enable per data byte
    localparam int unsigned OBI_BE_WIDTH = OBI_DATA_WIDTH / 8;

    // ------------------------------------------------------------
    // Address phase
    // ------------------------------------------------------------

    // Held stable by the master until granted
    typedef struct packed {
        logic [OBI_ADDR_WIDTH-1:0] addr;
        logic                      we;
        logic [OBI_BE_WIDTH-1:0]   be;
        logic [OBI_DATA_WIDTH-1:0] wdata;
    } obi_req_t;

    // ------------------------------------------------------------
    // Response phase
    // ------------------------------------------------------------

    // Valid only while rvalid is high, no back-pressure
    typedef struct packed {
        logic [OBI_DATA_WIDTH-1:0] rdata;
        logic                      err;
    } obi_rsp_t;

endpackage

//--- hw/pma_pkg.sv
/*
 * Physical memory attribute types
 * Region descriptor, default region and the request tagged by the checker.
 */

package pma_pkg;

    // ------------------------------------------------------------
    // Region descriptor
    // ------------------------------------------------------------

    // Bounds are word addresses, high bound exclusive
    typedef struct packed {
        logic [31:0] word_addr_low;
        logic [31:0] word_addr_high;
        logic        main;
    } pma_cfg_t;

    // Main memory over the whole word space
    localparam pma_cfg_t PMA_R_DEFAULT = '{
        word_addr_low  : 32'h0000_0000,
        word_addr_high : 32'hFFFF_FFFF,
        main           : 1'b1
    };

    // ------------------------------------------------------------
    // Checked request
    // ------------------------------------------------------------

    // Bus request plus the outcome of the region lookup
    typedef struct packed {
        obi_pkg::obi_req_t req;
        logic              fault;
    } pma_req_t;

    // ------------------------------------------------------------
    // Helpers
    // ------------------------------------------------------------

    // Range test of one region, attribute not considered here
    function automatic logic pma_in_region(pma_cfg_t cfg, logic [31:0] word_addr);
        return (word_addr >= cfg.word_addr_low) && (word_addr < cfg.word_addr_high);
    endfunction

endpackage

//--- hw/pma_checker.sv
/*
 * PMA checker
 * Looks up each data request in the region table and flags accesses
 * that hit no main-memory region. Purely combinational, also owns the grant.
 */

`timescale 1ns/1ps

module pma_checker #(
    parameter int                PMA_NUM_REGIONS = 1,
    parameter pma_pkg::pma_cfg_t PMA_CFG[PMA_NUM_REGIONS-1:0] =
        '{default: pma_pkg::PMA_R_DEFAULT}
) (
    // Address phase from the master
    input  logic                req_i,
    input  obi_pkg::obi_req_t   req_pld_i,
    output logic                gnt_o,

    // Queue side
    input  logic                full_i,
    output logic                push_o,
    output pma_pkg::pma_req_t   checked_o
);

    import pma_pkg::*;

    // Byte address to word address
    logic [31:0] word_addr;

    // Set once a main region has claimed the request
    logic        main_hit;
    logic        fault;

    assign word_addr = req_pld_i.addr >> 2;

    // ------------------------------------------------------------
    // Region scan
    // ------------------------------------------------------------

    // Table order is priority order
    always_comb begin
        main_hit = 1'b0;
        for (int i = 0; i < PMA_NUM_REGIONS; i++) begin
            // Only the first main match counts
            if (!main_hit && PMA_CFG[i].main && pma_in_region(PMA_CFG[i], word_addr)) begin
                main_hit = 1'b1;
            end
        end
    end

    // Empty table means no checking at all
    assign fault = (PMA_NUM_REGIONS > 0) && !main_hit;

    // ------------------------------------------------------------
    // Handshake and output
    // ------------------------------------------------------------

    // Grant whenever there is room, independent of req
    assign gnt_o  = !full_i;

    // Push on the accept edge
    assign push_o = req_i && gnt_o;

    // Payload passes through untouched, fault bit appended
    assign checked_o.req   = req_pld_i;
    assign checked_o.fault = fault;

endmodule

//--- hw/obi_req_fifo.sv
/*
 * Checked request queue
 * Circular buffer holding accepted requests in order until the RAM
 * takes them. Full level backs up into the grant.
 */

`timescale 1ns/1ps

module obi_req_fifo #(
    parameter int FIFO_DEPTH = 4
) (
    input  logic              clk_i,
    input  logic              rst_n_i,

    // Write side, from the checker
    input  logic              push_i,
    input  pma_pkg::pma_req_t push_data_i,
    output logic              full_o,

    // Read side, to the RAM
    input  logic              pop_i,
    output logic              valid_o,
    output pma_pkg::pma_req_t head_o
);

    import pma_pkg::*;

    localparam int PTR_W = $clog2(FIFO_DEPTH);
    localparam int CNT_W = PTR_W + 1;

    localparam logic [CNT_W-1:0] FULL_COUNT = CNT_W'(FIFO_DEPTH);

    // Storage, no reset on payload
    pma_req_t         entries [FIFO_DEPTH];

    logic [PTR_W-1:0] wr_ptr;
    logic [PTR_W-1:0] rd_ptr;
    logic [CNT_W-1:0] count;

    logic             do_push;
    logic             do_pop;

    // ------------------------------------------------------------
    // Level and strobes
    // ------------------------------------------------------------

    assign full_o  = (count == FULL_COUNT);
    assign valid_o = (count != '0);

    assign do_pop  = pop_i && valid_o;

    // A pop on the same edge frees the slot for a push when full
    assign do_push = push_i && (!full_o || do_pop);

    assign head_o  = entries[rd_ptr];

    // ------------------------------------------------------------
    // Pointers and count
    // ------------------------------------------------------------

    always_ff @(posedge clk_i) begin
        if (!rst_n_i) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            // Depth is a power of two, pointers wrap by themselves
            if (do_push) begin
                wr_ptr <= wr_ptr + 1'b1;
            end
            if (do_pop) begin
                rd_ptr <= rd_ptr + 1'b1;
            end
            // Simultaneous push and pop leaves the count alone
            if (do_push && !do_pop) begin
                count <= count + 1'b1;
            end else if (do_pop && !do_push) begin
                count <= count - 1'b1;
            end
        end
    end

    // Entry write
    always_ff @(posedge clk_i) begin
        if (do_push) begin
            entries[wr_ptr] <= push_data_i;
        end
    end

endmodule

//--- hw/obi_data_mem.sv
/*
 * Data RAM with OBI response
 * Serves the queue head one request per cycle with byte-enabled writes
 * and registers the rvalid/rdata/err response.
 */

`timescale 1ns/1ps

module obi_data_mem #(
    parameter int RAM_ADDR_WIDTH = 12
) (
    input  logic              clk_i,
    input  logic              rst_n_i,

    // Queue head
    input  logic              valid_i,
    input  pma_pkg::pma_req_t head_i,
    output logic              pop_o,

    // Response phase
    output logic              rvalid_o,
    output obi_pkg::obi_rsp_t rsp_o
);

    import obi_pkg::*;

    localparam int IDX_W     = RAM_ADDR_WIDTH - 2;
    localparam int NUM_WORDS = 2 ** IDX_W;

    // Word RAM, contents survive reset
    logic [OBI_DATA_WIDTH-1:0] ram [NUM_WORDS];

    obi_req_t         req;
    logic             fault;
    logic [IDX_W-1:0] word_idx;
    logic             wr_en;
    obi_rsp_t         rsp_d;

    // ------------------------------------------------------------
    // Decode of the head entry
    // ------------------------------------------------------------

    assign req   = head_i.req;
    assign fault = head_i.fault;

    // Upper address bits alias onto the RAM
    assign word_idx = req.addr[RAM_ADDR_WIDTH-1:2];

    // Every valid head is taken on this edge
    assign pop_o = valid_i;

    // Faulted writes never reach the array
    assign wr_en = valid_i && req.we && !fault;

    // ------------------------------------------------------------
    // Next response
    // ------------------------------------------------------------

    always_comb begin
        rsp_d.rdata = '0;
        rsp_d.err   = fault;
        // Reads only, writes and faults answer zero
        if (!req.we && !fault) begin
            rsp_d.rdata = ram[word_idx];
        end
    end

    // ------------------------------------------------------------
    // Array write
    // ------------------------------------------------------------

    always_ff @(posedge clk_i) begin
        if (wr_en) begin
            for (int b = 0; b < OBI_BE_WIDTH; b++) begin
                // Per-byte lane enable
                if (req.be[b]) begin
                    ram[word_idx][b*8 +: 8] <= req.wdata[b*8 +: 8];
                end
            end
        end
    end

    // ------------------------------------------------------------
    // Response registers
    // ------------------------------------------------------------

    // One-cycle rvalid per popped entry
    always_ff @(posedge clk_i) begin
        if (!rst_n_i) begin
            rvalid_o <= 1'b0;
        end else begin
            rvalid_o <= valid_i;
        end
    end

    // Payload only, sampled when a head is served
    always_ff @(posedge clk_i) begin
        if (valid_i) begin
            rsp_o <= rsp_d;
        end
    end

endmodule

//--- hw/obi_mem_subsys.sv
/*
 * OBI data memory subsystem
 * PMA check, in-order request queue and byte-enabled word RAM behind
 * one OBI data port.
 */

`timescale 1ns/1ps

module obi_mem_subsys #(
    // Region table
    parameter int                PMA_NUM_REGIONS = 1,
    parameter pma_pkg::pma_cfg_t PMA_CFG[PMA_NUM_REGIONS-1:0] =
        '{default: pma_pkg::PMA_R_DEFAULT},
    // Queue and RAM sizing
    parameter int                FIFO_DEPTH      = 4,
    parameter int                RAM_ADDR_WIDTH  = 12
) (
    input  logic              clk_i,
    input  logic              rst_n_i,

    // Address phase
    input  logic              data_req_i,
    output logic              data_gnt_o,
    input  obi_pkg::obi_req_t data_req_pld_i,

    // Response phase
    output logic              data_rvalid_o,
    output obi_pkg::obi_rsp_t data_rsp_o
);

    import pma_pkg::*;

    // Checker to queue
    logic     fifo_push;
    logic     fifo_full;
    pma_req_t checked_req;

    // Queue to RAM
    logic     fifo_valid;
    logic     fifo_pop;
    pma_req_t head_req;

    // ------------------------------------------------------------
    // Bus side, region check and grant
    // ------------------------------------------------------------

    pma_checker #(
        .PMA_NUM_REGIONS (PMA_NUM_REGIONS),
        .PMA_CFG         (PMA_CFG)
    ) i_pma_checker (
        .req_i     (data_req_i),
        .req_pld_i (data_req_pld_i),
        .gnt_o     (data_gnt_o),
        .full_i    (fifo_full),
        .push_o    (fifo_push),
        .checked_o (checked_req)
    );

    // ------------------------------------------------------------
    // Request queue
    // ------------------------------------------------------------

    obi_req_fifo #(
        .FIFO_DEPTH (FIFO_DEPTH)
    ) i_req_fifo (
        .clk_i       (clk_i),
        .rst_n_i     (rst_n_i),
        .push_i      (fifo_push),
        .push_data_i (checked_req),
        .full_o      (fifo_full),
        .pop_i       (fifo_pop),
        .valid_o     (fifo_valid),
        .head_o      (head_req)
    );

    // ------------------------------------------------------------
    // RAM and response phase
    // ------------------------------------------------------------

    obi_data_mem #(
        .RAM_ADDR_WIDTH (RAM_ADDR_WIDTH)
    ) i_data_mem (
        .clk_i    (clk_i),
        .rst_n_i  (rst_n_i),
        .valid_i  (fifo_valid),
        .head_i   (head_req),
        .pop_o    (fifo_pop),
        .rvalid_o (data_rvalid_o),
        .rsp_o    (data_rsp_o)
    );

endmodule

//--- verification/obi_mem_subsys_tb.sv
/*
 * Testbench for the OBI data memory subsystem
 * Drives the data port, predicts each response with a reference model
 * and checks grant level, response values and response order.
 */

`timescale 1ns/1ps

module obi_mem_subsys_tb;

    import obi_pkg::*;
    import pma_pkg::*;

    localparam int RAM_AW      = 12;
    localparam int FIFO_DEPTH  = 4;
    localparam int PMA_REGIONS = 2;
    localparam int RAM_WORDS   = 1 << (RAM_AW - 2);
    localparam int CLK_HALF    = 20;
    localparam int DRAIN_LIMIT = FIFO_DEPTH + 8;
    localparam int NUM_RANDOM  = 500;

    // About 600 requests at up to 4 cycles each, plus margin
    localparam int MAX_CYCLES  = 600 * 4 + 1600;

    // Main memory below word 0x200, non-main up to 0x300, nothing above
    localparam pma_cfg_t TB_PMA_CFG [PMA_REGIONS-1:0] = '{
        0: '{word_addr_low: 32'h000, word_addr_high: 32'h200, main: 1'b1},
        1: '{word_addr_low: 32'h200, word_addr_high: 32'h300, main: 1'b0}
    };

    logic        clk_i;
    logic        rst_n_i;
    logic        data_req_i;
    logic        data_gnt_o;
    obi_req_t    data_req_pld_i;
    logic        data_rvalid_o;
    obi_rsp_t    data_rsp_o;

    // Reference model state
    logic [31:0] model_ram [RAM_WORDS];
    obi_rsp_t    exp_q [$];
    int          model_count = 0;
    int          pending     = 0;

    // Edge bookkeeping and counters
    int          cycle_cnt   = 0;
    int          accept_edge = 0;
    int          rsp_edge    = 0;
    int          req_cnt     = 0;
    int          rsp_cnt     = 0;
    int          check_cnt   = 0;
    int          err_cnt     = 0;
    int          err_base    = 0;

    obi_mem_subsys #(
        .PMA_NUM_REGIONS (PMA_REGIONS),
        .PMA_CFG         (TB_PMA_CFG),
        .FIFO_DEPTH      (FIFO_DEPTH),
        .RAM_ADDR_WIDTH  (RAM_AW)
    ) i_dut (
        .clk_i          (clk_i),
        .rst_n_i        (rst_n_i),
        .data_req_i     (data_req_i),
        .data_gnt_o     (data_gnt_o),
        .data_req_pld_i (data_req_pld_i),
        .data_rvalid_o  (data_rvalid_o),
        .data_rsp_o     (data_rsp_o)
    );

    always #(CLK_HALF) clk_i = ~clk_i;

    always @(posedge clk_i) begin
        cycle_cnt <= cycle_cnt + 1;
    end

    // ------------------------------------------------------------
    // Checks
    // ------------------------------------------------------------

    task automatic report_mismatch(input string sig, input logic [31:0] got,
                                   input logic [31:0] exp);
        $display("[FAIL] %0s got %h expected %h at cycle %0d", sig, got, exp, cycle_cnt);
        err_cnt++;
    endtask

    task automatic check_gnt(input logic exp);
        check_cnt++;
        if (data_gnt_o !== exp) begin
            report_mismatch("data_gnt_o", data_gnt_o, exp);
        end
    endtask

    // Data and error bit compared on their own
    task automatic check_rsp(input obi_rsp_t exp);
        check_cnt += 2;
        if (data_rsp_o.rdata !== exp.rdata) begin
            report_mismatch("data_rsp_o.rdata", data_rsp_o.rdata, exp.rdata);
        end
        if (data_rsp_o.err !== exp.err) begin
            report_mismatch("data_rsp_o.err", data_rsp_o.err, exp.err);
        end
    endtask

    // ------------------------------------------------------------
    // Reference model
    // ------------------------------------------------------------

    // Region lookup, then the access on the model RAM
    function automatic obi_rsp_t expect_rsp(input obi_req_t req);
        logic [31:0] word_addr;
        logic        hit;
        int          idx;
        obi_rsp_t    rsp;
        word_addr = req.addr >> 2;
        hit = 1'b0;
        for (int i = 0; i < PMA_REGIONS; i++) begin
            if (!hit && TB_PMA_CFG[i].main && word_addr >= TB_PMA_CFG[i].word_addr_low
                && word_addr < TB_PMA_CFG[i].word_addr_high) begin
                hit = 1'b1;
            end
        end
        idx = word_addr % RAM_WORDS;
        rsp.rdata = '0;
        rsp.err = (PMA_REGIONS > 0) && !hit;
        if (!rsp.err && req.we) begin
            for (int b = 0; b < 4; b++) begin
                if (req.be[b]) begin
                    model_ram[idx][b*8 +: 8] = req.wdata[b*8 +: 8];
                end
            end
        end else if (!rsp.err) begin
            rsp.rdata = model_ram[idx];
        end
        return rsp;
    endfunction

    function automatic obi_req_t build_req(input logic we, input logic [31:0] word,
                                           input logic [3:0] be, input logic [31:0] wdata);
        obi_req_t req;
        req.addr  = word << 2;
        req.we    = we;
        req.be    = be;
        req.wdata = wdata;
        return req;
    endfunction

    // ------------------------------------------------------------
    // Driver
    // ------------------------------------------------------------

    // One clock from falling edge to falling edge, occupancy tracked at the edge
    task automatic tick(input logic active, input obi_req_t req, output logic accepted);
        check_gnt(model_count < FIFO_DEPTH);
        accepted = active && data_gnt_o;
        @(posedge clk_i);
        // Non-empty queue loses its head on every edge
        if (model_count > 0) begin
            model_count--;
        end
        if (accepted) begin
            model_count++;
            exp_q.push_back(expect_rsp(req));
        end
        pending = exp_q.size();
        @(negedge clk_i);
        if (accepted) begin
            accept_edge = cycle_cnt;
        end
    endtask

    // Request stays high afterwards, so calls in a row form a burst
    task automatic issue(input obi_req_t req);
        logic accepted;
        accepted = 1'b0;
        data_req_i = 1'b1;
        data_req_pld_i = req;
        while (!accepted) begin
            tick(1'b1, req, accepted);
        end
        req_cnt++;
    endtask

    task automatic idle(input int cycles);
        logic accepted;
        data_req_i = 1'b0;
        data_req_pld_i = '0;
        repeat (cycles) tick(1'b0, '0, accepted);
    endtask

    task automatic drain();
        int waited;
        waited = 0;
        do begin
            idle(1);
            waited++;
        end while (pending != 0 && waited < DRAIN_LIMIT);
        if (pending != 0) begin
            $display("Responses missing: %0d request(s) never answered", pending);
            err_cnt++;
            exp_q.delete();
        end
    endtask

    task automatic end_test(input string name);
        drain();
        $display("Test %-12s done, %0d error(s)", name, err_cnt - err_base);
        err_base = err_cnt;
    endtask

    // ------------------------------------------------------------
    // Monitor and watchdog
    // ------------------------------------------------------------

    always @(negedge clk_i) begin
        if (rst_n_i === 1'b1 && data_rvalid_o === 1'b1) begin
            // Edge at which the master samples this rvalid
            rsp_edge = cycle_cnt + 1;
            rsp_cnt++;
            if (exp_q.size() == 0) begin
                $display("Response at cycle %0d with no request outstanding", cycle_cnt);
                err_cnt++;
            end else begin
                check_rsp(exp_q.pop_front());
            end
        end
    end

    initial begin
        wait (cycle_cnt >= MAX_CYCLES);
        $display("Timeout: run still going after %0d cycles", MAX_CYCLES);
        $display("TESTBENCH FAILED");
        $finish;
    end

    // ------------------------------------------------------------
    // Stimulus
    // ------------------------------------------------------------

    initial begin
        logic [3:0]  be_pat [4];
        logic [31:0] word;
        int          sel;
        be_pat = '{4'b0001, 4'b0110, 4'b1000, 4'b1010};
        void'($urandom(32'h7d23d2cb));
        clk_i = 1'b0;
        rst_n_i = 1'b0;
        data_req_i = 1'b0;
        data_req_pld_i = '0;
        repeat (3) @(negedge clk_i);
        rst_n_i = 1'b1;

        // Idle state, then one read on an empty queue
        check_cnt++;
        if (data_rvalid_o !== 1'b0) begin
            report_mismatch("data_rvalid_o", data_rvalid_o, 0);
        end
        check_gnt(1'b1);
        issue(build_req(1'b1, 32'h10, 4'hF, 32'hCAFE_0010));
        drain();
        issue(build_req(1'b0, 32'h10, 4'hF, '0));
        drain();
        check_cnt++;
        if (rsp_edge - accept_edge != 2) begin
            report_mismatch("data_rvalid_o latency", rsp_edge - accept_edge, 2);
        end
        end_test("reset_read");

        // Full words, then partial byte enables over them
        for (int k = 0; k < 8; k++) issue(build_req(1'b1, k, 4'hF, $urandom));
        for (int k = 0; k < 8; k++) issue(build_req(1'b0, k, 4'hF, '0));
        for (int k = 0; k < 8; k++) issue(build_req(1'b1, k, be_pat[k % 4], $urandom));
        for (int k = 0; k < 8; k++) issue(build_req(1'b0, k, 4'hF, '0));
        end_test("write_read");

        // Non-main and uncovered space, word k aliased from 0x400 + k
        for (int k = 0; k < 4; k++) begin
            issue(build_req(1'b1, 32'h200 + k, 4'hF, $urandom));
            issue(build_req(1'b0, 32'h200 + k, 4'hF, '0));
            issue(build_req(1'b1, 32'h400 + k, 4'hF, $urandom));
            issue(build_req(1'b0, 32'h300 + k, 4'hF, '0));
            issue(build_req(1'b0, k, 4'hF, '0));
        end
        issue(build_req(1'b1, 32'h3FFF_FFFC, 4'hF, $urandom));
        end_test("faults");

        // Back-to-back with req held high, grant follows the model every cycle
        for (int k = 0; k < 6; k++) begin
            issue(build_req(1'b1, 32'h20 + k, 4'hF, $urandom));
            issue(build_req(1'b0, 32'h20 + k, 4'hF, '0));
        end
        end_test("burst");

        // Known contents in the random window first
        for (int k = 0; k < 64; k++) issue(build_req(1'b1, k, 4'hF, $urandom));
        for (int n = 0; n < NUM_RANDOM; n++) begin
            sel = $urandom_range(9, 0);
            word = $urandom_range(63, 0);
            if (sel == 7) begin
                word = word + 32'h200;
            end else if (sel == 8) begin
                word = word + 32'h400;
            end else if (sel == 9) begin
                word = $urandom_range(32'h3FFF_FFFF, 32'h300);
            end
            issue(build_req($urandom_range(1, 0), word, $urandom_range(15, 0), $urandom));
            idle($urandom_range(2, 0));
        end
        end_test("random");

        $display("Requests %0d, responses %0d, checks %0d, errors %0d",
                 req_cnt, rsp_cnt, check_cnt, err_cnt);
        if (err_cnt == 0) begin
            $display("TESTBENCH PASSED");
        end else begin
            $display("TESTBENCH FAILED");
        end
        $finish;
    end

endmodule

//--- obi_mem_subsys.f
hw/obi_pkg.sv
hw/pma_pkg.sv
hw/pma_checker.sv
hw/obi_req_fifo.sv
hw/obi_data_mem.sv
hw/obi_mem_subsys.sv
verification/obi_mem_subsys_tb.sv
